// File: branch_macros.svh
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// number of rob entries
// a power of two, so indices wrap on their own
`define ROB_DEPTH 64

// slots per dispatch group, slot 0 oldest
`define DISPATCH_WIDTH 4

// unresolved branches the core tracks at once
`define BRANCH_WINDOW 2

`endif

// File: rob_pkg.sv
`default_nettype none

`include "branch_macros.svh"

package rob_pkg;

   typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;      // rob entry index
   typedef logic [$clog2(`ROB_DEPTH):0]   rob_cnt_t;      // occupancy 0..ROB_DEPTH

   // instructions moved in one cycle, 0..DISPATCH_WIDTH
   typedef logic [$clog2(`DISPATCH_WIDTH):0] inst_cnt_t;

   // mispredict reported by execute
   typedef struct packed {
      logic     valid;
      rob_idx_t idx;         // rob index of the mispredicted branch
   } resolve_t;

   // retirement at the rob head
   typedef struct packed {
      inst_cnt_t retire_cnt;   // entries retired this cycle
      logic      is_branch;    // oldest retiring instr is a branch
      rob_idx_t  branch_idx;
   } commit_t;

endpackage

`default_nettype wire

// File: dispatch_pkg.sv
`default_nettype none

`include "branch_macros.svh"

package dispatch_pkg;

   import rob_pkg::*;

   // one instruction slot of a dispatch group
   typedef struct packed {
      logic valid;
      logic is_branch;
   } slot_t;

   // slot 0 holds the oldest instruction
   typedef slot_t [`DISPATCH_WIDTH-1:0] dispatch_group_t;

   // one bit per slot
   typedef logic [`DISPATCH_WIDTH-1:0] slot_mask_t;

   // result of the dispatch gate for the current group
   typedef struct packed {
      logic       accept;     // whole group goes in this cycle
      rob_idx_t   base;       // rob tail before allocation
      slot_mask_t br_mask;    // valid branch slots
      inst_cnt_t  slot_cnt;   // valid slots
   } alloc_t;

endpackage

`default_nettype wire

// File: dispatch_gate.sv
`default_nettype none

`include "branch_macros.svh"

module dispatch_gate
   import rob_pkg::*, dispatch_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire dispatch_group_t group,
   input  wire rob_cnt_t        rob_free,        // free rob entries
   input  wire rob_idx_t        rob_tail,
   input  wire [1:0]            branch_count,    // branches in flight
   input  wire                  commit_branch,   // oldest branch retires now
   input  wire                  resolve_valid,   // mispredict this cycle
   output alloc_t               alloc,
   output logic                 stall
);

   slot_mask_t valid_mask;
   slot_mask_t br_mask;
   inst_cnt_t  valid_cnt;
   inst_cnt_t  br_cnt;
   logic       any_valid;
   logic       rob_fits;
   logic       win_fits;
   logic       accept;

   // per-slot masks and counts
   always_comb
   begin
      valid_cnt = '0;
      br_cnt    = '0;
      for (int k = 0; k < `DISPATCH_WIDTH; k++)
      begin
         valid_mask[k] = group[k].valid;
         br_mask[k]    = group[k].valid & group[k].is_branch;
         valid_cnt     = valid_cnt + inst_cnt_t'(valid_mask[k]);
         br_cnt        = br_cnt + inst_cnt_t'(br_mask[k]);
      end
   end

   assign any_valid = (valid_cnt != '0);

   assign rob_fits = (rob_cnt_t'(valid_cnt) <= rob_free);

   // a committing branch frees its window slot in the same cycle
   // compare without subtracting so nothing underflows
   assign win_fits = ((br_cnt + inst_cnt_t'(branch_count)) <=
                      (inst_cnt_t'(`BRANCH_WINDOW) + inst_cnt_t'(commit_branch)));

   // a flush this cycle would squash the group anyway
   assign accept = any_valid & rob_fits & win_fits & ~resolve_valid;

   assign stall = any_valid & ~accept;

   always_comb
   begin
      alloc.accept   = accept;
      alloc.base     = rob_tail;
      alloc.br_mask  = br_mask;
      alloc.slot_cnt = valid_cnt;
   end

   // front end packs slots from slot 0
   // so the valid mask plus one is a power of two
   a_slots_packed: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot({1'b0, valid_mask} + 1'b1));

endmodule

`default_nettype wire

// File: rob_alloc.sv
`default_nettype none

`include "branch_macros.svh"

module rob_alloc
   import rob_pkg::*, dispatch_pkg::*;
(
   input  wire           clk,
   input  wire           rst_n,
   input  wire alloc_t   alloc,
   input  wire commit_t  commit,
   input  wire           flush,       // rollback request
   input  wire rob_idx_t flush_idx,   // new tail on rollback
   output rob_idx_t      rob_tail,
   output rob_idx_t      rob_head,
   output rob_cnt_t      rob_count,
   output rob_cnt_t      rob_free
);

   rob_idx_t tail_q;
   rob_idx_t tail_nxt;
   rob_idx_t head_q;
   rob_idx_t head_nxt;
   rob_cnt_t count_q;
   rob_cnt_t count_nxt;
   rob_cnt_t alloc_cnt;
   rob_cnt_t retire_cnt;
   rob_idx_t keep_dist;
   rob_cnt_t keep_cnt;

   assign alloc_cnt  = alloc.accept ? rob_cnt_t'(alloc.slot_cnt) : '0;
   assign retire_cnt = rob_cnt_t'(commit.retire_cnt);

   // entries kept on rollback, head up to and including the branch
   assign keep_dist = flush_idx - head_q;

   // zero distance means the branch holds the last slot of a full rob
   assign keep_cnt = (keep_dist == '0) ? rob_cnt_t'(`ROB_DEPTH)
                                       : {1'b0, keep_dist};

   always_comb
   begin
      head_nxt  = head_q + rob_idx_t'(commit.retire_cnt);   // wraps at depth
      tail_nxt  = tail_q;
      count_nxt = count_q + alloc_cnt - retire_cnt;
      if (flush)
      begin
         tail_nxt  = flush_idx;                 // squash everything younger
         count_nxt = keep_cnt - retire_cnt;
      end
      else if (alloc.accept)
         tail_nxt = tail_q + rob_idx_t'(alloc.slot_cnt);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tail_q  <= '0;
         head_q  <= '0;
         count_q <= '0;
      end
      else
      begin
         tail_q  <= tail_nxt;
         head_q  <= head_nxt;
         count_q <= count_nxt;
      end
   end

   assign rob_tail  = tail_q;
   assign rob_head  = head_q;
   assign rob_count = count_q;
   assign rob_free  = rob_cnt_t'(`ROB_DEPTH) - count_q;

   // the retiring side only retires what dispatch put in
   a_retire_le_count: assert property (@(posedge clk) disable iff (!rst_n)
      retire_cnt <= count_q);

   // gate and rollback together keep occupancy in range
   a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
      count_q <= rob_cnt_t'(`ROB_DEPTH));

endmodule

`default_nettype wire

// File: branch_fifo.sv
`default_nettype none

`include "branch_macros.svh"

module branch_fifo
   import rob_pkg::*, dispatch_pkg::*;
(
   input  wire           clk,
   input  wire           rst_n,
   input  wire alloc_t   alloc,
   input  wire resolve_t resolve,
   input  wire commit_t  commit,
   output logic          flush,
   output rob_idx_t      flush_idx,
   output logic [1:0]    branch_count,
   output rob_idx_t      oldest_branch
);

   rob_idx_t   entry [2];        // rob indices, program order from head
   logic       head_q;
   logic       head_nxt;
   logic       tail_q;
   logic       tail_nxt;
   logic [1:0] count_q;
   logic [1:0] count_nxt;
   rob_idx_t   new_idx [2];      // older and younger new branch
   logic [1:0] new_cnt;
   logic       commit_hit;
   logic       mis_head;

   // pick up to two branches from the group, oldest slot first
   always_comb
   begin
      new_idx[0] = alloc.base;
      new_idx[1] = alloc.base;
      new_cnt    = '0;
      for (int k = 0; k < `DISPATCH_WIDTH; k++)
      begin
         if (alloc.br_mask[k])
         begin
            if (new_cnt == 2'd0)
               new_idx[0] = alloc.base + rob_idx_t'(k);   // wraps past 63
            else
               new_idx[1] = alloc.base + rob_idx_t'(k);
            new_cnt = new_cnt + 2'd1;
         end
      end
      if (!alloc.accept)
         new_cnt = '0;              // stalled group writes nothing
   end

   assign commit_hit = commit.is_branch && (count_q != '0) &&
                       (commit.branch_idx == entry[head_q]);

   assign mis_head = resolve.valid && (count_q != '0) &&
                     (resolve.idx == entry[head_q]);

   always_comb
   begin
      head_nxt  = commit_hit ? ~head_q : head_q;
      tail_nxt  = tail_q ^ new_cnt[0];            // two writes land back on tail
      count_nxt = count_q + new_cnt - {1'b0, commit_hit};
      if (mis_head)
      begin
         // oldest branch wrong, everything behind it is gone
         head_nxt  = 1'b0;
         tail_nxt  = 1'b0;
         count_nxt = '0;
      end
      else if (resolve.valid)
      begin
         tail_nxt  = ~tail_q;                     // drop the younger entry
         count_nxt = count_q - 2'd1 - {1'b0, commit_hit};
      end
   end

   // payload only, gated by count
   always_ff @(posedge clk)
   begin
      if (new_cnt != '0)
         entry[tail_q] <= new_idx[0];
      if (new_cnt == 2'd2)
         entry[~tail_q] <= new_idx[1];
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q  <= 1'b0;
         tail_q  <= 1'b0;
         count_q <= '0;
      end
      else
      begin
         head_q  <= head_nxt;
         tail_q  <= tail_nxt;
         count_q <= count_nxt;
      end
   end

   assign flush         = resolve.valid;
   assign flush_idx     = resolve.idx + 1'b1;     // first squashed entry
   assign branch_count  = count_q;
   assign oldest_branch = entry[head_q];

   // rob retires in order, so a retiring branch is the oldest one held
   a_commit_is_oldest: assert property (@(posedge clk) disable iff (!rst_n)
      commit.is_branch |-> commit_hit);

   // execute only reports branches dispatched earlier and still open
   a_resolve_present: assert property (@(posedge clk) disable iff (!rst_n)
      resolve.valid |-> mis_head ||
                        ((count_q == 2'd2) && (resolve.idx == entry[~head_q])));

   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      count_q <= 2'(`BRANCH_WINDOW));

endmodule

`default_nettype wire

// File: branch_window_top.sv
`default_nettype none

module branch_window_top
   import rob_pkg::*, dispatch_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire dispatch_group_t group,
   input  wire resolve_t        resolve,
   input  wire commit_t         commit,
   output logic                 stall,
   output alloc_t               alloc,
   output logic                 flush,
   output rob_idx_t             flush_idx,
   output logic [1:0]           branch_count,
   output rob_idx_t             oldest_branch,
   output rob_cnt_t             rob_count,
   output rob_idx_t             rob_tail
);

   rob_cnt_t rob_free;

   // accept or stall the whole group
   dispatch_gate u_gate (
      .clk           (clk),
      .rst_n         (rst_n),
      .group         (group),
      .rob_free      (rob_free),
      .rob_tail      (rob_tail),
      .branch_count  (branch_count),
      .commit_branch (commit.is_branch),
      .resolve_valid (resolve.valid),
      .alloc         (alloc),
      .stall         (stall)
   );

   // head is only needed inside the allocator for rollback counting
   rob_alloc u_rob_alloc (
      .clk       (clk),
      .rst_n     (rst_n),
      .alloc     (alloc),
      .commit    (commit),
      .flush     (flush),
      .flush_idx (flush_idx),
      .rob_tail  (rob_tail),
      .rob_head  (),
      .rob_count (rob_count),
      .rob_free  (rob_free)
   );

   // unresolved branches, also the source of rollback
   branch_fifo u_branch_fifo (
      .clk           (clk),
      .rst_n         (rst_n),
      .alloc         (alloc),
      .resolve       (resolve),
      .commit        (commit),
      .flush         (flush),
      .flush_idx     (flush_idx),
      .branch_count  (branch_count),
      .oldest_branch (oldest_branch)
   );

endmodule

`default_nettype wire

// File: tb_branch_window.sv
`default_nettype none

`include "branch_macros.svh"

module tb_branch_window
   import rob_pkg::*, dispatch_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // phase lengths in cycles for the watchdog
   localparam int IDLE_CYC   = 4;
   localparam int FILL_CYC   = 300;
   localparam int BRANCH_CYC = 300;
   localparam int MIXED_CYC  = 400;
   localparam int DRAIN_CYC  = 40;
   localparam int TOTAL_CYC  = 16 + IDLE_CYC + FILL_CYC + BRANCH_CYC + MIXED_CYC + DRAIN_CYC;

   logic            clk;
   logic            rst_n;
   dispatch_group_t group;
   resolve_t        resolve;
   commit_t         commit;
   logic            stall;
   alloc_t          alloc;
   logic            flush;
   rob_idx_t        flush_idx;
   logic [1:0]      branch_count;
   rob_idx_t        oldest_branch;
   rob_cnt_t        rob_count;
   rob_idx_t        rob_tail;

   integer seed = 1;
   int     err_cnt = 0;
   int     n_acc = 0;
   int     n_stall = 0;
   int     n_wrap = 0;
   int     n_bcommit = 0;
   int     n_flush_old = 0;
   int     n_flush_young = 0;
   // percentages for the running phase
   int     p_grp;
   int     p_br;
   int     p_cmt;
   int     p_rsv;

   // reference model state
   rob_idx_t        m_tail = '0;
   rob_idx_t        m_head = '0;
   rob_cnt_t        m_count = '0;
   rob_idx_t        bq [$];               // unresolved branches in program order
   logic [1:0]      m_bcnt = '0;
   rob_idx_t        m_oldest = '0;

   // stimulus of the current cycle and what the model expects from it
   dispatch_group_t cur_grp = '0;
   commit_t         cur_cmt = '0;
   resolve_t        cur_rsv = '0;
   logic            m_accept = 1'b0;
   logic            m_stall = 1'b0;
   logic            m_flush = 1'b0;
   rob_idx_t        m_flush_idx = '0;
   inst_cnt_t       m_slots = '0;
   slot_mask_t      m_brmask = '0;

   branch_window_top u_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .group         (group),
      .resolve       (resolve),
      .commit        (commit),
      .stall         (stall),
      .alloc         (alloc),
      .flush         (flush),
      .flush_idx     (flush_idx),
      .branch_count  (branch_count),
      .oldest_branch (oldest_branch),
      .rob_count     (rob_count),
      .rob_tail      (rob_tail)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   function automatic int ring_distance(input rob_idx_t from_idx, input rob_idx_t to_idx);
      rob_idx_t d;
      d = to_idx - from_idx;       // wraps at rob depth
      return int'(d);
   endfunction

   task automatic note_mismatch(input string name, input int got, input int exp);
      err_cnt++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
   endtask

   task automatic note_failure(input string what);
      err_cnt++;
      $display("check failed at %0t: %s", $time, what);
   endtask

   // apply the events of the cycle that just ended to the model
   task automatic update_model();
      rob_idx_t old_head;
      int       keep;
      int       cnt;
      old_head = m_head;
      cnt      = int'(m_count);
      m_head   = m_head + rob_idx_t'(cur_cmt.retire_cnt);
      if (m_stall)
         n_stall++;
      if (m_flush)
      begin
         keep = ring_distance(old_head, m_flush_idx);   // head up to the branch
         if (keep == 0)
            keep = `ROB_DEPTH;
         cnt    = keep - int'(cur_cmt.retire_cnt);
         m_tail = m_flush_idx;
         if (cur_rsv.idx == bq[0])
         begin
            bq.delete();
            n_flush_old++;
         end
         else
         begin
            void'(bq.pop_back());
            n_flush_young++;
         end
      end
      else
      begin
         cnt = cnt - int'(cur_cmt.retire_cnt);
         if (m_accept)
         begin
            cnt = cnt + int'(m_slots);
            if (int'(m_tail) + int'(m_slots) >= `ROB_DEPTH)
               n_wrap++;
            for (int k = 0; k < `DISPATCH_WIDTH; k++)
               if (cur_grp[k].valid && cur_grp[k].is_branch)
                  bq.push_back(m_tail + rob_idx_t'(k));
            m_tail = m_tail + rob_idx_t'(m_slots);
            n_acc++;
         end
      end
      if (cur_cmt.is_branch)
      begin
         void'(bq.pop_front());
         n_bcommit++;
      end
      m_count = rob_cnt_t'(cnt);
      m_bcnt  = 2'(bq.size());
      if (bq.size() != 0)
         m_oldest = bq[0];
   endtask

   // pick legal events for the next cycle and the expected gate result
   task automatic pick_stimulus();
      int       nv;
      int       nbr;
      int       lim;
      int       r;
      commit_t  c;
      resolve_t s;
      if (!m_stall)                         // a stalled group is held
      begin
         cur_grp = '0;
         if (rand_below(100) < p_grp)
         begin
            nv = 1 + rand_below(`DISPATCH_WIDTH);
            for (int k = 0; k < nv; k++)
            begin
               cur_grp[k].valid     = 1'b1;
               cur_grp[k].is_branch = (rand_below(100) < p_br);
            end
         end
      end
      c = '0;
      if (rand_below(100) < p_cmt)
      begin
         lim = int'(m_count);
         if (bq.size() != 0 && bq[0] == m_head)
         begin
            // oldest entry is a branch so retire stops before the next one
            c.is_branch  = 1'b1;
            c.branch_idx = bq[0];
            if (bq.size() > 1)
               lim = ring_distance(m_head, bq[1]);
         end
         else if (bq.size() != 0)
            lim = ring_distance(m_head, bq[0]);
         if (lim > `DISPATCH_WIDTH)
            lim = `DISPATCH_WIDTH;
         if (lim > 0)
            c.retire_cnt = inst_cnt_t'(1 + rand_below(lim));
      end
      s = '0;
      if (bq.size() != 0 && rand_below(100) < p_rsv)
      begin
         r = c.is_branch ? 1 : rand_below(bq.size());   // never the committing one
         if (r < bq.size())
         begin
            s.valid = 1'b1;
            s.idx   = bq[r];
         end
      end
      nv  = 0;
      nbr = 0;
      for (int k = 0; k < `DISPATCH_WIDTH; k++)
      begin
         m_brmask[k] = cur_grp[k].valid && cur_grp[k].is_branch;
         nv          = nv + int'(cur_grp[k].valid);
         nbr         = nbr + int'(m_brmask[k]);
      end
      m_slots     = inst_cnt_t'(nv);
      m_accept    = (nv != 0) && (nv <= `ROB_DEPTH - int'(m_count)) &&
                    (nbr + bq.size() - int'(c.is_branch) <= `BRANCH_WINDOW) && !s.valid;
      m_stall     = (nv != 0) && !m_accept;
      m_flush     = s.valid;
      m_flush_idx = s.idx + 1'b1;
      cur_cmt     = c;
      cur_rsv     = s;
   endtask

   task automatic run_phase(input string name, input int cycles, input int grp_pct,
                            input int br_pct, input int cmt_pct, input int rsv_pct);
      int err_before;
      err_before = err_cnt;
      p_grp = grp_pct;
      p_br  = br_pct;
      p_cmt = cmt_pct;
      p_rsv = rsv_pct;
      repeat (cycles)
      begin
         @(posedge clk);
         update_model();
         pick_stimulus();
         group   <= cur_grp;
         commit  <= cur_cmt;
         resolve <= cur_rsv;
      end
      $display("phase %-7s %0d cycles, %0d errors", name, cycles, err_cnt - err_before);
   endtask

   initial
   begin
      rst_n   = 1'b0;
      group   = '0;
      resolve = '0;
      commit  = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      run_phase("idle", IDLE_CYC, 0, 0, 0, 0);
      run_phase("fill", FILL_CYC, 90, 5, 25, 2);       // rob runs full
      run_phase("branch", BRANCH_CYC, 70, 40, 40, 10);  // window runs full
      run_phase("mixed", MIXED_CYC, 60, 25, 50, 8);
      run_phase("drain", DRAIN_CYC, 0, 0, 60, 0);
      repeat (2) @(posedge clk);
      $write("summary: %0d accepted, %0d stalled, %0d wraps, %0d branch commits,",
             n_acc, n_stall, n_wrap, n_bcommit);
      $display(" %0d flush oldest, %0d flush younger, %0d errors",
               n_flush_old, n_flush_young, err_cnt);
      if (err_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   initial
   begin
      #((TOTAL_CYC + 200) * 4);
      $display("timeout: run did not finish within %0d ns", (TOTAL_CYC + 200) * 4);
      $display("Testbench failed");
      $finish;
   end

   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      !stall && !flush && !alloc.accept && branch_count == 0 && rob_count == 0 && rob_tail == 0)
      else note_failure("outputs not in reset state after reset release");

   a_accept: assert property (@(posedge clk) disable iff (!rst_n) alloc.accept == m_accept)
      else note_mismatch("alloc.accept", $sampled(alloc.accept), $sampled(m_accept));

   a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == m_stall)
      else note_mismatch("stall", $sampled(stall), $sampled(m_stall));

   a_base: assert property (@(posedge clk) disable iff (!rst_n) m_accept |-> alloc.base == m_tail)
      else note_mismatch("alloc.base", $sampled(alloc.base), $sampled(m_tail));

   a_slots: assert property (@(posedge clk) disable iff (!rst_n)
      m_accept |-> alloc.slot_cnt == m_slots)
      else note_mismatch("alloc.slot_cnt", $sampled(alloc.slot_cnt), $sampled(m_slots));

   a_br_mask: assert property (@(posedge clk) disable iff (!rst_n)
      m_accept |-> alloc.br_mask == m_brmask)
      else note_mismatch("alloc.br_mask", $sampled(alloc.br_mask), $sampled(m_brmask));

   a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush == m_flush)
      else note_mismatch("flush", $sampled(flush), $sampled(m_flush));

   a_flush_idx: assert property (@(posedge clk) disable iff (!rst_n)
      m_flush |-> flush_idx == m_flush_idx)
      else note_mismatch("flush_idx", $sampled(flush_idx), $sampled(m_flush_idx));

   a_tail: assert property (@(posedge clk) disable iff (!rst_n) rob_tail == m_tail)
      else note_mismatch("rob_tail", $sampled(rob_tail), $sampled(m_tail));

   a_count: assert property (@(posedge clk) disable iff (!rst_n) rob_count == m_count)
      else note_mismatch("rob_count", $sampled(rob_count), $sampled(m_count));

   a_bcount: assert property (@(posedge clk) disable iff (!rst_n) branch_count == m_bcnt)
      else note_mismatch("branch_count", $sampled(branch_count), $sampled(m_bcnt));

   a_oldest: assert property (@(posedge clk) disable iff (!rst_n)
      m_bcnt != 0 |-> oldest_branch == m_oldest)
      else note_mismatch("oldest_branch", $sampled(oldest_branch), $sampled(m_oldest));

   // a stalled group leaves the tail and the branch window alone
   a_stall_tail: assert property (@(posedge clk) disable iff (!rst_n)
      stall && !flush |=> $stable(rob_tail))
      else note_failure("rob_tail moved after a stalled cycle");

   a_stall_window: assert property (@(posedge clk) disable iff (!rst_n)
      stall && !flush && !commit.is_branch |=> $stable(branch_count))
      else note_failure("branch_count moved after a stalled cycle");

endmodule

`default_nettype wire

// File: list.f
+incdir+.
rob_pkg.sv
dispatch_pkg.sv
dispatch_gate.sv
rob_alloc.sv
branch_fifo.sv
branch_window_top.sv
tb_branch_window.sv
